// File: dv/smu_ctrl_props.sv
// frame controller checks, attached to spi_frame_ctrl by bind
// both pulses last one clk, read_req only once the address byte is in

`timescale 1ns/1ps

module smu_ctrl_props (
  input logic clk,
  input logic rst,
  input logic read_req,
  input logic commit,
  input spi_frame_pkg::bit_cnt_t bit_cnt
);

  import spi_frame_pkg::*;

  read_req_pulse: assert property (@(posedge clk) disable iff (rst) read_req |=> !read_req)
    else $error("read_req high for more than one cycle");

  commit_pulse: assert property (@(posedge clk) disable iff (rst) commit |=> !commit)
    else $error("commit high for more than one cycle");

  // count has just reached the end of the address byte
  read_req_at_byte: assert property (
    @(posedge clk) disable iff (rst) read_req |-> bit_cnt == bit_cnt_t'(addr_bits))
    else $error("read_req with a bit count other than 8");

  quiet_in_reset: assert property (@(posedge clk) rst |=> !read_req && !commit)
    else $error("read_req or commit high during reset");

endmodule

bind spi_frame_ctrl smu_ctrl_props smu_ctrl_props_i (
  .clk(clk), .rst(rst), .read_req(read_req), .commit(commit), .bit_cnt(bit_cnt)
);

// File: dv/smu_ctrl_tb.sv
// testbench for smu_ctrl_top, host spi bit-banged at 8 clk per sck phase
// register outputs checked against a shadow model after every frame
// stops at the first mismatch, needs a simulator with timing support

`timescale 1ns/1ps

module smu_ctrl_tb;

  import smu_reg_pkg::*;

  localparam int half_clks = 8;
  localparam int n_random = 80;
  localparam int n_mux = 4;
  // random writes, two bad lengths, soft reset, mux writes, reads of 7 to 24
  localparam int num_frames = n_random + 3 + n_mux + 17;
  // longest frame plus lead, tail, gap and the mux checks
  localparam int frame_clks = 17 * 2 * half_clks + 2 * half_clks + 20;
  localparam int timeout_ns = (num_frames * frame_clks + 200) * 10;

  logic clk;
  logic rst;
  logic spi_sck;
  logic spi_cs_n;
  logic spi_mosi;
  logic periph_cs2_n;
  logic [num_periph-1:0] periph_miso;
  logic [1:0] mon_rails;
  logic spi_miso;
  logic [num_periph-1:0] periph_cs_n;
  nibble_t reg_led;
  nibble_t reg_dac;
  nibble_t reg_rails;
  nibble_t reg_dac_ref_mux;
  nibble_t reg_adc;
  nibble_t reg_clamp1;
  nibble_t reg_clamp2;
  nibble_t reg_rails_oe;

  // shadow of every address, only writable ones change
  nibble_t shadow [0:255];
  logic [31:0] lfsr;
  event frame_done;

  smu_ctrl_top smu_ctrl_top_i (.*);

  always #5 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // checks

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_nibble(input string what, input nibble_t got, input nibble_t exp);
    if (got !== exp)
      report_failure($sformatf("Mismatch at %0t: %s is %h, expected %h",
                               $time, what, got, exp));
  endtask

  task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp)
      report_failure($sformatf("Mismatch at %0t: %s is %h, expected %h",
                               $time, what, got, exp));
  endtask

  task automatic check_cs(input logic [num_periph-1:0] got, input logic [num_periph-1:0] exp);
    if (got !== exp)
      report_failure($sformatf("Mismatch at %0t: periph_cs_n is %b, expected %b",
                               $time, got, exp));
  endtask

  task automatic check_regs();
    check_nibble("reg_led", reg_led, shadow[addr_led]);
    check_nibble("reg_dac", reg_dac, shadow[addr_dac]);
    check_nibble("reg_rails", reg_rails, shadow[addr_rails]);
    check_nibble("reg_dac_ref_mux", reg_dac_ref_mux, shadow[addr_dac_ref_mux]);
    check_nibble("reg_adc", reg_adc, shadow[addr_adc]);
    check_nibble("reg_clamp1", reg_clamp1, shadow[addr_clamp1]);
    check_nibble("reg_clamp2", reg_clamp2, shadow[addr_clamp2]);
    check_nibble("reg_rails_oe", reg_rails_oe, shadow[addr_rails_oe]);
    // cs2 is high here, no peripheral selected
    check_cs(periph_cs_n, 4'hF);
  endtask

  //////////////////////////////////////////////////////////////////////
  // random source and reference model

  // fibonacci, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output logic [7:0] v);
    v = 8'h00;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_step(lfsr);
      v = {v[6:0], lfsr[0]};
    end
  endtask

  // overlap toggles, else set then clear
  function automatic nibble_t expected_update(input nibble_t old, input nibble_t s,
                                              input nibble_t c);
    if ((s & c) != 4'h0)
      return old ^ (s & c);
    else
      return (old & ~c) | (s & ~c);
  endfunction

  function automatic logic is_writable(input reg_addr_t a);
    case (a)
      addr_led, addr_mux, addr_dac, addr_rails, addr_dac_ref_mux,
      addr_adc, addr_clamp1, addr_clamp2, addr_rails_oe: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // one complete 16-bit frame
  task automatic model_frame(input reg_addr_t a, input logic [7:0] d);
    if (a == addr_soft_reset)
    begin
      // clamps active low, rails kept disabled
      shadow = '{default: 4'h0};
      shadow[addr_clamp1] = 4'hF;
      shadow[addr_clamp2] = 4'hF;
      shadow[addr_rails_oe] = 4'h1;
    end
    else if (is_writable(a))
      shadow[a] = expected_update(shadow[a], d[3:0], d[7:4]);
  endtask

  //////////////////////////////////////////////////////////////////////
  // spi host

  // mode 0, msb first, miso sampled just before each rising sck
  task automatic spi_xfer(input int nbits, input logic [16:0] data, output logic [15:0] rx);
    logic [16:0] sh;
    sh = data << (17 - nbits);
    rx = 16'h0000;
    spi_cs_n = 1'b0;
    for (int i = 0; i < nbits; i++)
    begin
      spi_mosi = sh[16];
      sh = sh << 1;
      repeat (half_clks) @(negedge clk);
      rx = {rx[14:0], spi_miso};
      spi_sck = 1'b1;
      repeat (half_clks) @(negedge clk);
      spi_sck = 1'b0;
    end
    repeat (half_clks) @(negedge clk);
    spi_cs_n = 1'b1;
    if (nbits == 16)
      model_frame(data[15:8], data[7:0]);
    -> frame_done;
    // gap covers the compare below
    repeat (10) @(negedge clk);
  endtask

  // write lands 4 clk after cs release
  always @(frame_done)
  begin
    repeat (6) @(negedge clk);
    check_regs();
  end

  //////////////////////////////////////////////////////////////////////
  // sequence

  initial
  begin
    logic [15:0] rx;
    logic [7:0] r;
    logic [7:0] d;
    logic [7:0] exp;
    reg_addr_t a;
    clk = 1'b0;
    rst = 1'b1;
    spi_sck = 1'b0;
    spi_cs_n = 1'b1;
    spi_mosi = 1'b0;
    periph_cs2_n = 1'b1;
    periph_miso = 4'h0;
    mon_rails = 2'b00;
    lfsr = 32'h8318;
    model_frame(addr_soft_reset, 8'h00);
    repeat (5) @(negedge clk);
    rst = 1'b0;
    repeat (2) @(negedge clk);
    check_regs();
    // random writes over 7 to 24, unknown and read-only ones included
    for (int n = 0; n < n_random; n++)
    begin
      rand_bits(5, r);
      a = 8'd7 + 8'(r[4:0] % 5'd18);
      if (a == addr_soft_reset)
        a = addr_mux;
      rand_bits(8, d);
      spi_xfer(16, {1'b0, a, d}, rx);
    end
    // soft reset ignores the data byte
    spi_xfer(16, {1'b0, addr_soft_reset, 8'h50}, rx);
    // wrong lengths are dropped
    // zero low nibble left by the reset frame
    // so a short frame taken as a write would set led
    spi_xfer(12, {5'h00, addr_led[3:0], 8'h0F}, rx);
    // last 16 bits form a led write
    spi_xfer(17, {1'b0, addr_led, 8'h0F}, rx);
    // cs2 routing
    for (int n = 0; n < n_mux; n++)
    begin
      rand_bits(8, d);
      spi_xfer(16, {1'b0, addr_mux, d}, rx);
      periph_cs2_n = 1'b0;
      @(negedge clk);
      check_cs(periph_cs_n, ~shadow[addr_mux]);
      repeat (4)
      begin
        rand_bits(4, r);
        periph_miso = r[3:0];
        @(negedge clk);
        check_byte("routed spi_miso", {7'h00, spi_miso},
                   {7'h00, |(shadow[addr_mux] & periph_miso)});
      end
      periph_cs2_n = 1'b1;
      periph_miso = 4'h0;
      @(negedge clk);
      check_cs(periph_cs_n, 4'hF);
    end
    // readback, zero low byte leaves registers alone
    for (int k = 7; k <= 24; k++)
    begin
      a = reg_addr_t'(k);
      if (a != addr_soft_reset)
      begin
        rand_bits(2, r);
        mon_rails = r[1:0];
        spi_xfer(16, {1'b0, a, 8'h00}, rx);
        if (is_writable(a))
          exp = {4'h0, shadow[a]};
        else if (a == addr_mon_rails)
          exp = {6'h00, mon_rails};
        else
          exp = 8'hFF;
        check_byte($sformatf("readback of address %0d", a), rx[7:0], exp);
      end
    end
    repeat (10) @(negedge clk);
    $display("Testbench passed");
    $finish;
  end

  initial
  begin
    #(timeout_ns);
    report_failure($sformatf("Timeout: run not finished after %0d ns", timeout_ns));
  end

endmodule

// File: logic/smu_ctrl_top.sv
// smu control fpga, spi register bank plus cs2 peripheral routing
// sck and mosi fan out to the peripherals on the board, not here

`timescale 1ns/1ps

module smu_ctrl_top (
  input  logic clk,
  input  logic rst,
  input  logic spi_sck,
  input  logic spi_cs_n,
  input  logic spi_mosi,
  input  logic periph_cs2_n,
  input  logic [smu_reg_pkg::num_periph-1:0] periph_miso,
  input  logic [1:0] mon_rails,
  output logic spi_miso,
  output logic [smu_reg_pkg::num_periph-1:0] periph_cs_n,
  output smu_reg_pkg::nibble_t reg_led,
  output smu_reg_pkg::nibble_t reg_dac,
  output smu_reg_pkg::nibble_t reg_rails,
  output smu_reg_pkg::nibble_t reg_dac_ref_mux,
  output smu_reg_pkg::nibble_t reg_adc,
  output smu_reg_pkg::nibble_t reg_clamp1,
  output smu_reg_pkg::nibble_t reg_clamp2,
  output smu_reg_pkg::nibble_t reg_rails_oe
);

  import spi_frame_pkg::*;
  import smu_reg_pkg::*;

  // sampled spi
  logic sck_rise, sck_fall, cs_active, cs_end, mosi_s;
  // frame control
  logic read_req, commit;
  bit_cnt_t bit_cnt;
  // data path
  spi_frame_t frame;
  logic [7:0] rd_data;
  logic dout;
  nibble_t reg_mux;

  spi_sampler spi_sampler_i (
    .clk, .rst, .spi_sck, .spi_cs_n, .spi_mosi,
    .sck_rise, .sck_fall, .cs_active, .cs_end, .mosi_s
  );

  spi_frame_ctrl spi_frame_ctrl_i (
    .clk, .rst, .sck_rise, .cs_active, .cs_end,
    .read_req, .commit, .bit_cnt
  );

  spi_shifter spi_shifter_i (
    .clk, .rst, .sck_rise, .sck_fall, .cs_active, .mosi_s,
    .read_req, .rd_data, .frame, .dout
  );

  smu_reg_file smu_reg_file_i (
    .clk, .rst, .commit, .frame, .mon_rails, .rd_data,
    .reg_led, .reg_mux, .reg_dac, .reg_rails, .reg_dac_ref_mux,
    .reg_adc, .reg_clamp1, .reg_clamp2, .reg_rails_oe
  );

  spi_cs_router spi_cs_router_i (
    .periph_cs2_n, .reg_mux, .dout, .periph_miso, .periph_cs_n, .spi_miso
  );

endmodule

// File: logic/smu_reg_file.sv
// control registers with set / clear / toggle update
// soft reset at address 11 reloads all defaults
// readback decode is combinational from the address byte

`timescale 1ns/1ps

module smu_reg_file (
  input  logic clk,
  input  logic rst,
  input  logic commit,
  input  spi_frame_pkg::spi_frame_t frame,
  input  logic [1:0] mon_rails,
  output logic [7:0] rd_data,
  output smu_reg_pkg::nibble_t reg_led,
  output smu_reg_pkg::nibble_t reg_mux,
  output smu_reg_pkg::nibble_t reg_dac,
  output smu_reg_pkg::nibble_t reg_rails,
  output smu_reg_pkg::nibble_t reg_dac_ref_mux,
  output smu_reg_pkg::nibble_t reg_adc,
  output smu_reg_pkg::nibble_t reg_clamp1,
  output smu_reg_pkg::nibble_t reg_clamp2,
  output smu_reg_pkg::nibble_t reg_rails_oe
);

  import spi_frame_pkg::*;
  import smu_reg_pkg::*;

  logic load_def;

  // bits both set and cleared toggle, otherwise set then clear
  function automatic nibble_t apply_update(nibble_t old, nibble_t set, nibble_t clr);
    nibble_t overlap;
    overlap = set & clr;
    if (overlap != 4'h0)
      return old ^ overlap;
    else
      return (old | set) & ~clr;
  endfunction

  assign load_def = rst || (commit && frame.wr.addr == addr_soft_reset);

  //////////////////////////////////////////////////////////////////////
  // write side

  always_ff @(posedge clk)
  begin
    if (load_def)
    begin
      reg_led <= def_led;
      reg_mux <= def_mux;
      reg_dac <= def_dac;
      reg_rails <= def_rails;
      reg_dac_ref_mux <= def_dac_ref_mux;
      reg_adc <= def_adc;
      reg_clamp1 <= def_clamp1;
      reg_clamp2 <= def_clamp2;
      reg_rails_oe <= def_rails_oe;
    end
    else if (commit)
    begin
      // unknown and read-only addresses fall through
      case (frame.wr.addr)
        addr_led: reg_led <= apply_update(reg_led, frame.wr.set, frame.wr.clr);
        addr_mux: reg_mux <= apply_update(reg_mux, frame.wr.set, frame.wr.clr);
        addr_dac: reg_dac <= apply_update(reg_dac, frame.wr.set, frame.wr.clr);
        addr_rails: reg_rails <= apply_update(reg_rails, frame.wr.set, frame.wr.clr);
        addr_dac_ref_mux:
          reg_dac_ref_mux <= apply_update(reg_dac_ref_mux, frame.wr.set, frame.wr.clr);
        addr_adc: reg_adc <= apply_update(reg_adc, frame.wr.set, frame.wr.clr);
        addr_clamp1: reg_clamp1 <= apply_update(reg_clamp1, frame.wr.set, frame.wr.clr);
        addr_clamp2: reg_clamp2 <= apply_update(reg_clamp2, frame.wr.set, frame.wr.clr);
        addr_rails_oe: reg_rails_oe <= apply_update(reg_rails_oe, frame.wr.set, frame.wr.clr);
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read side

  always_comb
  begin
    case (frame.rd.rd_addr)
      addr_led: rd_data = {4'h0, reg_led};
      addr_mux: rd_data = {4'h0, reg_mux};
      addr_dac: rd_data = {4'h0, reg_dac};
      addr_rails: rd_data = {4'h0, reg_rails};
      addr_dac_ref_mux: rd_data = {4'h0, reg_dac_ref_mux};
      addr_adc: rd_data = {4'h0, reg_adc};
      addr_clamp1: rd_data = {4'h0, reg_clamp1};
      addr_clamp2: rd_data = {4'h0, reg_clamp2};
      addr_mon_rails: rd_data = {6'h00, mon_rails};
      addr_rails_oe: rd_data = {4'h0, reg_rails_oe};
      default: rd_data = read_dummy;
    endcase
  end

endmodule

// File: logic/smu_reg_pkg.sv
// register map of the smu control fpga
// all control registers are 4 bits wide

package smu_reg_pkg;

  typedef logic [3:0] nibble_t;
  typedef logic [7:0] reg_addr_t;

  //////////////////////////////////////////////////////////////////////
  // register addresses

  localparam reg_addr_t addr_led = 8'd7;
  localparam reg_addr_t addr_mux = 8'd8;
  localparam reg_addr_t addr_dac = 8'd9;
  localparam reg_addr_t addr_rails = 8'd10;
  localparam reg_addr_t addr_soft_reset = 8'd11;
  localparam reg_addr_t addr_dac_ref_mux = 8'd12;
  localparam reg_addr_t addr_adc = 8'd14;
  localparam reg_addr_t addr_clamp1 = 8'd15;
  localparam reg_addr_t addr_clamp2 = 8'd16;
  localparam reg_addr_t addr_mon_rails = 8'd19;   // read only
  localparam reg_addr_t addr_rails_oe = 8'd24;

  //////////////////////////////////////////////////////////////////////
  // defaults, loaded on rst and on soft reset

  localparam nibble_t def_led = 4'h0;
  localparam nibble_t def_mux = 4'h0;
  localparam nibble_t def_dac = 4'h0;
  localparam nibble_t def_rails = 4'h0;
  // dg444 switches off while the rails are down
  localparam nibble_t def_dac_ref_mux = 4'h0;
  localparam nibble_t def_adc = 4'h0;
  // clamp switches are active low, all off
  localparam nibble_t def_clamp1 = 4'hF;
  localparam nibble_t def_clamp2 = 4'hF;
  // rail enable is active low, keep disabled until host is ready
  localparam nibble_t def_rails_oe = 4'h1;

  // peripherals behind cs2
  localparam int num_periph = 4;

  // unknown read address and first miso byte
  localparam logic [7:0] read_dummy = 8'hFF;

endpackage

// File: logic/spi_cs_router.sv
// routes host spi to the peripherals while cs2 is low
// purely combinational, follows cs2 and reg_mux directly

`timescale 1ns/1ps

module spi_cs_router (
  input  logic periph_cs2_n,
  input  smu_reg_pkg::nibble_t reg_mux,
  input  logic dout,
  input  logic [smu_reg_pkg::num_periph-1:0] periph_miso,
  output logic [smu_reg_pkg::num_periph-1:0] periph_cs_n,
  output logic spi_miso
);

  import smu_reg_pkg::*;

  // cs2 high, peripherals released and fpga drives miso
  // cs2 low, selected peripherals get cs and share miso
  always_comb
  begin
    if (periph_cs2_n)
    begin
      periph_cs_n = '1;
      spi_miso = dout;
    end
    else
    begin
      periph_cs_n = ~reg_mux;
      spi_miso = |(reg_mux & periph_miso);
    end
  end

endmodule

// File: logic/spi_frame_ctrl.sv
// bit counter and frame decisions
// a frame commits only with exactly 16 bits, others are dropped
// count saturates so very long frames never wrap back to 16

`timescale 1ns/1ps

module spi_frame_ctrl (
  input  logic clk,
  input  logic rst,
  input  logic sck_rise,
  input  logic cs_active,
  input  logic cs_end,
  output logic read_req,
  output logic commit,
  output spi_frame_pkg::bit_cnt_t bit_cnt
);

  import spi_frame_pkg::*;

  localparam bit_cnt_t cnt_max = '1;
  localparam bit_cnt_t cnt_read = bit_cnt_t'(addr_bits - 1);
  localparam bit_cnt_t cnt_frame = bit_cnt_t'(frame_bits);

  logic bit_in;

  // a data bit arrives this cycle
  assign bit_in = sck_rise & cs_active;

  //////////////////////////////////////////////////////////////////////
  // bit count

  always_ff @(posedge clk)
  begin
    if (rst)
      bit_cnt <= '0;
    else if (cs_end)
      bit_cnt <= '0;
    else if (bit_in && bit_cnt != cnt_max)
      bit_cnt <= bit_cnt + bit_cnt_t'(1);
  end

  //////////////////////////////////////////////////////////////////////
  // read point

  // fires in the cycle the count becomes 8
  // address byte is then complete in the shifter
  always_ff @(posedge clk)
  begin
    if (rst)
      read_req <= 1'b0;
    else
      read_req <= bit_in && (bit_cnt == cnt_read);
  end

  //////////////////////////////////////////////////////////////////////
  // commit

  // same cycle as cs_end, count not yet cleared
  // register file updates on the next edge
  assign commit = cs_end && (bit_cnt == cnt_frame);

endmodule

// File: logic/spi_frame_pkg.sv
// spi frame format shared by the shifter, frame controller and register file
// 16-bit frames only, msb first, address byte first

package spi_frame_pkg;

  localparam int frame_bits = 16;
  localparam int addr_bits = 8;

  // write view, the whole frame as seen at cs release
  typedef struct packed {
    logic [7:0] addr;
    logic [3:0] clr;   // high nibble clears
    logic [3:0] set;   // low nibble sets
  } spi_wr_t;

  // read view, only the first byte has arrived
  // it still sits in the low half of the shift word
  typedef struct packed {
    logic [7:0] unused;
    logic [7:0] rd_addr;
  } spi_rd_t;

  typedef union packed {
    spi_wr_t wr;
    spi_rd_t rd;
  } spi_frame_t;

  // received bit count, wide enough for overlong frames
  typedef logic [4:0] bit_cnt_t;

endpackage

// File: logic/spi_sampler.sv
// spi pins are asynchronous to clk, two flop synchronizer each
// edge pulses appear 3 clk after the pin edge
// each sck phase must last at least 4 clk

`timescale 1ns/1ps

module spi_sampler (
  input  logic clk,
  input  logic rst,
  input  logic spi_sck,
  input  logic spi_cs_n,
  input  logic spi_mosi,
  output logic sck_rise,
  output logic sck_fall,
  output logic cs_active,
  output logic cs_end,
  output logic mosi_s
);

  // [0],[1] synchronizer, [2] previous sample for edge detect
  logic [2:0] sck_q;
  logic [2:0] cs_n_q;
  logic [1:0] mosi_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      // idle levels, mode 0 sck low and cs released
      sck_q <= 3'b000;
      cs_n_q <= 3'b111;
      mosi_q <= 2'b00;
      sck_rise <= 1'b0;
      sck_fall <= 1'b0;
      cs_active <= 1'b0;
      cs_end <= 1'b0;
      mosi_s <= 1'b0;
    end
    else
    begin
      sck_q <= {sck_q[1:0], spi_sck};
      cs_n_q <= {cs_n_q[1:0], spi_cs_n};
      mosi_q <= {mosi_q[0], spi_mosi};
      // registered pulses, mosi kept aligned with sck_rise
      sck_rise <= sck_q[1] & ~sck_q[2];
      sck_fall <= ~sck_q[1] & sck_q[2];
      cs_active <= ~cs_n_q[1];
      cs_end <= cs_n_q[1] & ~cs_n_q[2];
      mosi_s <= mosi_q[1];
    end
  end

endmodule

// File: logic/spi_shifter.sv
// mode 0 shift registers, mosi in on rising sck, miso out on falling sck
// readback is loaded after the address byte and leaves in bits 9 to 16

`timescale 1ns/1ps

module spi_shifter (
  input  logic clk,
  input  logic rst,
  input  logic sck_rise,
  input  logic sck_fall,
  input  logic cs_active,
  input  logic mosi_s,
  input  logic read_req,
  input  logic [7:0] rd_data,
  output spi_frame_pkg::spi_frame_t frame,
  output logic dout
);

  import spi_frame_pkg::*;
  import smu_reg_pkg::*;

  // output word, msb goes out next
  logic [7:0] out_q;

  //////////////////////////////////////////////////////////////////////
  // input side

  // msb first, shift toward the top
  always_ff @(posedge clk)
  begin
    if (sck_rise && cs_active)
      frame <= {frame[frame_bits-2:0], mosi_s};
  end

  //////////////////////////////////////////////////////////////////////
  // output side

  always_ff @(posedge clk)
  begin
    if (rst || !cs_active)
    begin
      // idle, first byte is all ones
      out_q <= read_dummy;
      dout <= read_dummy[7];
    end
    else if (read_req)
      out_q <= rd_data;
    else if (sck_fall)
    begin
      // dout is its own flop so the load after bit 8 is not skipped
      dout <= out_q[7];
      out_q <= {out_q[6:0], 1'b1};
    end
  end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# builds the smu control testbench with verilator, runs it, checks the log
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log
obj=obj_dir

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
    -f verilog.f --top-module smu_ctrl_tb -Mdir "$obj" -o smu_ctrl_sim; then
  echo "verilator build failed"
  exit 1
fi

"./$obj/smu_ctrl_sim" > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Testbench passed$" "$log"; then
  exit 0
fi
echo "pass line not found in $log"
exit 1

// File: verilog.f
logic/spi_frame_pkg.sv
logic/smu_reg_pkg.sv
logic/spi_sampler.sv
logic/spi_shifter.sv
logic/spi_frame_ctrl.sv
logic/smu_reg_file.sv
logic/spi_cs_router.sv
logic/smu_ctrl_top.sv
dv/smu_ctrl_props.sv
dv/smu_ctrl_tb.sv
